// ==== project.f ====
common/cache_pkg.sv
common/gen_bus_if.sv
common/cache_array_if.sv
cache/cache_array.sv
cache/set_walker.sv
cache/cache_ctrl.sv
rtl/l1_cache_top.sv
dv/mem_model.sv
dv/tb_l1_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the L1 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        -f project.f --top-module tb_l1_cache > "$BUILD_LOG" 2>&1; then
    echo "compile failed, see $BUILD_LOG"
    exit 1
fi

if ! ./obj_dir/Vtb_l1_cache > "$SIM_LOG" 2>&1; then
    echo "simulation exited with an error, see $SIM_LOG"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$SIM_LOG"; then
    echo "test failed, see $SIM_LOG"
    exit 1
fi

echo "test passed"
exit 0

// ==== dv/tb_l1_cache.sv ====
// testbench for the L1 data cache
// table of accesses checked against a shadow copy of memory

module tb_l1_cache import cache_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam word_t CACHE_SIZE     = DEF_CACHE_SIZE;
    localparam word_t BLOCK_SIZE     = DEF_BLOCK_SIZE;
    localparam word_t NONCACHE_START = DEF_NONCACHE_START;
    localparam int    N_SETS         = CACHE_SIZE / 4 / BLOCK_SIZE;

    // A and B share an index with different tags, N is uncached
    localparam word_t A_ADDR = 32'h0000_0100;
    localparam word_t B_ADDR = 32'h0000_0500;
    localparam word_t C_ADDR = 32'h0000_0208;
    localparam word_t D_ADDR = 32'h0000_1318;
    localparam word_t N_ADDR = 32'hF000_0010;

    typedef enum logic [2:0] {OP_READ, OP_WRITE, OP_FLUSH, OP_POKE, OP_PEEK} op_e;

    typedef struct packed {
        op_e      op;
        word_t    addr;
        word_t    wdata;    // poke value too
        byte_en_t be;
        word_t    exp;
        logic     derive;   // expected value comes from the shadow
    } op_t;

    logic     CLK, nRST, flush, ren, wen;
    word_t    addr, wdata, rdata;
    byte_en_t byte_en, mem_byte_en;
    logic     busy, flush_done, mem_ren, mem_wen, mem_busy;
    word_t    mem_addr, mem_wdata, mem_rdata;

    op_t   ops [$];
    word_t shadow [word_t];
    int    errors = 0;
    int    checks = 0;
    int    n_flush = 0;
    int    limit_cycles = 0;

    l1_cache_top #(
        .CACHE_SIZE     (CACHE_SIZE),
        .BLOCK_SIZE     (BLOCK_SIZE),
        .NONCACHE_START (NONCACHE_START)
    ) u_dut (
        .CLK (CLK), .nRST (nRST), .flush (flush), .ren (ren), .wen (wen),
        .addr (addr), .wdata (wdata), .byte_en (byte_en),
        .mem_rdata (mem_rdata), .mem_busy (mem_busy),
        .busy (busy), .rdata (rdata), .flush_done (flush_done),
        .mem_ren (mem_ren), .mem_wen (mem_wen), .mem_addr (mem_addr),
        .mem_wdata (mem_wdata), .mem_byte_en (mem_byte_en)
    );

    mem_model u_mem (
        .CLK (CLK), .nRST (nRST), .ren (mem_ren), .wen (mem_wen),
        .addr (mem_addr), .wdata (mem_wdata), .byte_en (mem_byte_en),
        .rdata (mem_rdata), .busy (mem_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic word_t shadow_word(input word_t a);
        word_t k;
        k = {a[31:2], 2'b00};
        return shadow.exists(k) ? shadow[k] : 'x;
    endfunction

    // enabled bytes of d replace those of old
    function automatic word_t merge_bytes(input word_t old, input word_t d, input byte_en_t be);
        word_t w;
        w = old;
        for (int i = 0; i < 4; i++)
            if (be[i])
                w[8*i +: 8] = d[8*i +: 8];
        return w;
    endfunction

    task automatic add_op(input op_e op, input word_t a, input word_t d, input byte_en_t be,
                          input word_t exp, input logic derive);
        ops.push_back('{op, a, d, be, exp, derive});
        if (op == OP_FLUSH)
            n_flush++;
    endtask

    task automatic load_region(input word_t base, input word_t salt);
        u_mem.preload(base, 8, salt);
        for (int i = 0; i < 8; i++)
            shadow[base + 4 * i] = u_mem.peek(base + 4 * i);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic apply_op(input op_t e);
        word_t got;
        word_t exp;
        int    pulses;
        exp = e.derive ? shadow_word(e.addr) : e.exp;
        case (e.op)
            OP_READ, OP_WRITE: begin
                @(posedge CLK);
                ren     <= (e.op == OP_READ);
                wen     <= (e.op == OP_WRITE);
                addr    <= e.addr;
                wdata   <= e.wdata;
                byte_en <= e.be;
                do @(negedge CLK); while (busy);   // completes at the next edge
                got = rdata;
                @(posedge CLK);
                ren <= 1'b0;
                wen <= 1'b0;
                if (e.op == OP_READ)
                    check_word("rdata", got, exp);
                else
                    shadow[{e.addr[31:2], 2'b00}] = merge_bytes(shadow_word(e.addr),
                                                                e.wdata, e.be);
            end
            OP_FLUSH: begin
                @(posedge CLK);
                flush <= 1'b1;
                @(posedge CLK);
                flush <= 1'b0;
                pulses = 0;
                do begin
                    @(negedge CLK);
                    if (flush_done)
                        pulses++;
                end while (pulses == 0);
                repeat (4) begin
                    @(negedge CLK);
                    if (flush_done)
                        pulses++;
                end
                checks++;
                assert (pulses == 1) else begin
                    errors++;
                    $display("** Error at %0t ns: flush_done pulses = %0d, expected 1",
                             $time, pulses);
                end
                // nothing dirty may stay behind in the cache
                foreach (shadow[k])
                    check_word($sformatf("mem[%h]", k), u_mem.peek(k), shadow[k]);
            end
            OP_POKE: begin
                @(negedge CLK);
                u_mem.poke(e.addr, e.wdata);
                shadow[{e.addr[31:2], 2'b00}] = e.wdata;
            end
            default: begin
                @(negedge CLK);
                check_word($sformatf("mem[%h]", e.addr), u_mem.peek(e.addr), exp);
            end
        endcase
    endtask

    task automatic build_table();
        add_op(OP_READ,  A_ADDR,     0, 4'hF, 0, 1);            // fill after reset
        add_op(OP_READ,  A_ADDR + 4, 0, 4'hF, 0, 1);
        add_op(OP_WRITE, A_ADDR,     32'h1122_3344, 4'hF, 0, 1);
        add_op(OP_READ,  A_ADDR,     0, 4'hF, 0, 1);
        add_op(OP_WRITE, A_ADDR + 4, 32'hAABB_CCDD, 4'b0011, 0, 1);  // half word
        add_op(OP_READ,  A_ADDR + 4, 0, 4'hF, 0, 1);
        add_op(OP_WRITE, A_ADDR,     32'h00EE_0000, 4'b0100, 0, 1);  // one byte
        add_op(OP_READ,  A_ADDR,     0, 4'hF, 0, 1);
        add_op(OP_READ,  B_ADDR,     0, 4'hF, 0, 1);            // evicts dirty A
        add_op(OP_READ,  A_ADDR,     0, 4'hF, 0, 1);
        add_op(OP_PEEK,  A_ADDR,     0, 4'hF, 0, 1);
        add_op(OP_PEEK,  A_ADDR + 4, 0, 4'hF, 0, 1);
        add_op(OP_WRITE, N_ADDR,     32'h1234_5678, 4'b1001, 0, 1);
        add_op(OP_PEEK,  N_ADDR,     0, 4'hF, 0, 1);
        add_op(OP_POKE,  N_ADDR,     32'hCAFE_F00D, 4'hF, 0, 1);
        add_op(OP_READ,  N_ADDR,     0, 4'hF, 32'hCAFE_F00D, 0);
        add_op(OP_WRITE, C_ADDR,     32'h5566_7788, 4'hF, 0, 1);
        add_op(OP_WRITE, D_ADDR,     32'h0000_9900, 4'b0010, 0, 1);
        add_op(OP_WRITE, A_ADDR + 4, 32'h7700_0000, 4'b1000, 0, 1);
        add_op(OP_FLUSH, 0,          0, 4'hF, 0, 1);
        add_op(OP_POKE,  C_ADDR,     32'h0BAD_CAFE, 4'hF, 0, 1);
        add_op(OP_READ,  C_ADDR,     0, 4'hF, 32'h0BAD_CAFE, 0);  // frame was dropped
        add_op(OP_READ,  D_ADDR,     0, 4'hF, 0, 1);
        add_op(OP_WRITE, B_ADDR + 4, 32'hFEED_BEEF, 4'hF, 0, 1);
        add_op(OP_READ,  B_ADDR + 4, 0, 4'hF, 0, 1);
        add_op(OP_FLUSH, 0,          0, 4'hF, 0, 1);
    endtask

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge CLK);
        $display("watchdog expired after %0d cycles, a transfer never completed",
                 limit_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main
        nRST    = 1'b0;
        flush   = 1'b0;
        ren     = 1'b0;
        wen     = 1'b0;
        addr    = '0;
        wdata   = '0;
        byte_en = '0;
        load_region(32'h0000_0100, 32'h0101_0101);
        load_region(32'h0000_0500, 32'h0505_0505);
        load_region(32'h0000_0200, 32'h0202_0202);
        load_region(32'h0000_1310, 32'h1313_1313);
        load_region(32'hF000_0010, 32'hF0F0_F0F0);
        build_table();
        limit_cycles = ops.size() * (2 * BLOCK_SIZE * 5 + 10) + (n_flush + 1) * N_SETS + 8;
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;
        foreach (ops[i])
            apply_op(ops[i]);
        repeat (2) @(posedge CLK);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== dv/mem_model.sv ====
// behavioral word memory for the cache testbench
// random wait states per beat, preload and direct peek/poke access

module mem_model import cache_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     ren,
    input  logic     wen,
    input  word_t    addr,
    input  word_t    wdata,
    input  byte_en_t byte_en,
    output word_t    rdata,
    output logic     busy
);

    timeunit 1ns;
    timeprecision 1ns;

    word_t  mem [word_t];             // sparse, keyed by word-aligned address
    integer seed = 32'hf0236ef8;
    int     wait_left;                // wait states left in the current beat

    // content of a word never written
    function automatic word_t fill_word(input word_t a);
        return {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
    endfunction

    function automatic word_t peek(input word_t a);
        word_t k;
        k = {a[31:2], 2'b00};
        if (mem.exists(k))
            return mem[k];
        return fill_word(k);
    endfunction

    task automatic poke(input word_t a, input word_t d);
        mem[{a[31:2], 2'b00}] = d;
    endtask

    task automatic preload(input word_t base, input int count, input word_t salt);
        for (int i = 0; i < count; i++)
            poke(base + 4 * i, fill_word(base + 4 * i) ^ salt);
    endtask

    task automatic write_lanes(input word_t a, input word_t d, input byte_en_t be);
        word_t w;
        w = peek(a);
        for (int i = 0; i < 4; i++)
            if (be[i])
                w[8*i +: 8] = d[8*i +: 8];
        poke(a, w);
    endtask

    assign busy  = (ren || wen) && (wait_left != 0);
    assign rdata = ren ? peek(addr) : 32'h0;

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_left <= 0;
        end else if (ren || wen) begin
            if (wait_left != 0) begin
                wait_left <= wait_left - 1;
            end else begin
                if (wen)
                    write_lanes(addr, wdata, byte_en);
                wait_left <= $random(seed) & 3;   // 0 to 3 for the next beat
            end
        end
    end

endmodule

// ==== rtl/l1_cache_top.sv ====
// direct-mapped write-back L1 data cache, top level
// plain processor and memory ports tied to the internal buses

module l1_cache_top import cache_pkg::*; #(
    parameter word_t CACHE_SIZE     = DEF_CACHE_SIZE,
    parameter word_t BLOCK_SIZE     = DEF_BLOCK_SIZE,
    parameter word_t NONCACHE_START = DEF_NONCACHE_START
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     flush,
    input  logic     ren,
    input  logic     wen,
    input  word_t    addr,
    input  word_t    wdata,
    input  byte_en_t byte_en,
    input  word_t    mem_rdata,
    input  logic     mem_busy,
    output logic     busy,
    output word_t    rdata,
    output logic     flush_done,
    output logic     mem_ren,
    output logic     mem_wen,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output byte_en_t mem_byte_en
);

    localparam int N_SETS  = CACHE_SIZE / 4 / BLOCK_SIZE;
    localparam int SET_W   = $clog2(N_SETS);
    localparam int OFF_W   = $clog2(BLOCK_SIZE);
    localparam int BLK_W   = (OFF_W > 0) ? OFF_W : 1;
    localparam int TAG_W   = WORD_W - SET_W - OFF_W - 2;
    localparam int FRAME_W = 2 + TAG_W + BLOCK_SIZE * WORD_W;

    logic             walk_restart;
    logic             walk_advance;
    logic             walk_skip;
    logic [SET_W-1:0] walk_set;
    logic [BLK_W-1:0] walk_word;
    logic             walk_finish;

    gen_bus_if proc_bus ();
    gen_bus_if mem_bus ();
    cache_array_if #(.SET_W(SET_W), .FRAME_W(FRAME_W)) arr_if ();

    // processor side
    assign proc_bus.ren     = ren;
    assign proc_bus.wen     = wen;
    assign proc_bus.addr    = addr;
    assign proc_bus.wdata   = wdata;
    assign proc_bus.byte_en = byte_en;
    assign busy             = proc_bus.busy;
    assign rdata            = proc_bus.rdata;

    // memory side
    assign mem_ren          = mem_bus.ren;
    assign mem_wen          = mem_bus.wen;
    assign mem_addr         = mem_bus.addr;
    assign mem_wdata        = mem_bus.wdata;
    assign mem_byte_en      = mem_bus.byte_en;
    assign mem_bus.rdata    = mem_rdata;
    assign mem_bus.busy     = mem_busy;

    cache_ctrl #(
        .CACHE_SIZE     (CACHE_SIZE),
        .BLOCK_SIZE     (BLOCK_SIZE),
        .NONCACHE_START (NONCACHE_START)
    ) u_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .flush_done   (flush_done),
        .proc         (proc_bus),
        .mem          (mem_bus),
        .arr          (arr_if),
        .walk_restart (walk_restart),
        .walk_advance (walk_advance),
        .walk_skip    (walk_skip),
        .walk_set     (walk_set),
        .walk_word    (walk_word),
        .walk_finish  (walk_finish)
    );

    cache_array #(
        .CACHE_SIZE (CACHE_SIZE),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_array (
        .CLK  (CLK),
        .nRST (nRST),
        .arr  (arr_if)
    );

    set_walker #(
        .CACHE_SIZE (CACHE_SIZE),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_walker (
        .CLK        (CLK),
        .nRST       (nRST),
        .restart    (walk_restart),
        .advance    (walk_advance),
        .skip_block (walk_skip),
        .set_idx    (walk_set),
        .word_idx   (walk_word),
        .finish     (walk_finish)
    );

endmodule

// ==== cache/cache_ctrl.sv ====
// cache controller FSM
// lookup and hits, block fill, victim write-back, flush walk and uncached pass-through

module cache_ctrl import cache_pkg::*; #(
    parameter word_t CACHE_SIZE     = DEF_CACHE_SIZE,
    parameter word_t BLOCK_SIZE     = DEF_BLOCK_SIZE,
    parameter word_t NONCACHE_START = DEF_NONCACHE_START,
    localparam int   N_SETS         = CACHE_SIZE / 4 / BLOCK_SIZE,
    localparam int   SET_W          = $clog2(N_SETS),
    localparam int   OFF_W          = $clog2(BLOCK_SIZE),
    localparam int   BLK_W          = (OFF_W > 0) ? OFF_W : 1,
    localparam int   TAG_W          = WORD_W - SET_W - OFF_W - 2
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             flush,
    output logic             flush_done,
    gen_bus_if.device        proc,
    gen_bus_if.host          mem,
    cache_array_if.ctrl      arr,
    output logic             walk_restart,
    output logic             walk_advance,
    output logic             walk_skip,
    input  logic [SET_W-1:0] walk_set,
    input  logic [BLK_W-1:0] walk_word,
    input  logic             walk_finish
);

    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [TAG_W-1:0]       tag;
        word_t [BLOCK_SIZE-1:0] data;
    } frame_t;

    cache_state_e     state, next_state;
    logic             flush_req;
    logic [BLK_W-1:0] fill_cnt;      // word within the block being moved
    logic             cnt_en, cnt_clr;
    word_t            mem_addr, next_mem_addr;
    word_t            req_addr, next_req_addr;

    frame_t           rd, wr, msk;
    logic [TAG_W-1:0] cur_tag, req_tag;
    logic [SET_W-1:0] cur_idx, req_idx;
    logic [BLK_W-1:0] cur_off;
    word_t            lane_bits;
    logic             pass, access, hit, same_req, pending_flush;
    logic             beat_done, last_beat;

    // word address from block fields
    function automatic word_t blk_addr(input logic [TAG_W-1:0] tag,
                                       input logic [SET_W-1:0] set,
                                       input logic [BLK_W-1:0] word);
        return (word_t'(tag) << (WORD_W - TAG_W))
             | (word_t'(set) << (OFF_W + 2))
             | (word_t'(word) << 2);
    endfunction

    assign rd         = frame_t'(arr.rframe);
    assign arr.wframe = wr;
    assign arr.wmask  = msk;

    // address decode
    assign cur_tag = proc.addr[WORD_W-1 -: TAG_W];
    assign cur_idx = SET_W'(proc.addr >> (OFF_W + 2));
    assign cur_off = BLK_W'((proc.addr >> 2) & (BLOCK_SIZE - 1));
    assign req_tag = req_addr[WORD_W-1 -: TAG_W];
    assign req_idx = SET_W'(req_addr >> (OFF_W + 2));

    assign pass          = (proc.addr >= NONCACHE_START);
    assign access        = proc.ren | proc.wen;
    assign hit           = !pass && rd.valid && (rd.tag == cur_tag);
    assign same_req      = access && (cur_tag == req_tag) && (cur_idx == req_idx);
    assign pending_flush = flush | flush_req;
    assign beat_done     = !mem.busy;
    assign last_beat     = beat_done && (fill_cnt == BLK_W'(BLOCK_SIZE - 1));
    assign lane_bits     = {{8{proc.byte_en[3]}}, {8{proc.byte_en[2]}},
                            {8{proc.byte_en[1]}}, {8{proc.byte_en[0]}}};

    always_comb begin
        next_state    = state;
        next_mem_addr = mem_addr;
        next_req_addr = req_addr;
        cnt_en        = 1'b0;
        cnt_clr       = 1'b0;
        arr.set_sel   = cur_idx;
        arr.wen       = 1'b0;
        wr            = '0;
        msk           = '1;   // keep everything by default
        proc.busy     = 1'b1;
        proc.rdata    = '0;
        mem.ren       = 1'b0;
        mem.wen       = 1'b0;
        mem.addr      = '0;
        mem.wdata     = '0;
        mem.byte_en   = '1;   // whole words for fills and evictions
        walk_restart  = 1'b0;
        walk_advance  = 1'b0;
        walk_skip     = 1'b0;
        flush_done    = 1'b0;

        case (state)
            INIT: begin
                arr.set_sel = walk_set;
                if (walk_finish) begin
                    walk_restart = 1'b1;
                    next_state   = LOOKUP;
                end else begin
                    arr.wen      = 1'b1;   // clear the whole frame
                    msk          = '0;
                    walk_advance = 1'b1;
                    walk_skip    = 1'b1;
                end
            end
            LOOKUP: begin
                cnt_clr = 1'b1;
                if (pending_flush) begin
                    next_state = FLUSH;
                end else if (pass && access) begin
                    mem.ren     = proc.ren;
                    mem.wen     = proc.wen;
                    mem.addr    = proc.addr;
                    mem.byte_en = proc.byte_en;
                    mem.wdata   = proc.wdata & lane_bits;  // disabled lanes zeroed
                    proc.busy   = mem.busy;
                    proc.rdata  = mem.rdata;
                end else if (hit && proc.ren) begin
                    proc.busy  = 1'b0;
                    proc.rdata = rd.data[cur_off];
                end else if (hit && proc.wen) begin
                    proc.busy             = 1'b0;
                    arr.wen               = 1'b1;
                    wr.dirty              = 1'b1;
                    msk.dirty             = 1'b0;
                    wr.data[cur_off]      = proc.wdata;
                    msk.data[cur_off]     = ~lane_bits;  // enabled bytes only
                end else if (access) begin
                    next_req_addr = proc.addr;
                    if (rd.valid && rd.dirty) begin
                        next_mem_addr = blk_addr(rd.tag, cur_idx, '0);   // victim block
                        next_state    = WRITEBACK;
                    end else begin
                        next_mem_addr = blk_addr(cur_tag, cur_idx, '0);
                        next_state    = FETCH;
                    end
                end
            end
            FETCH: begin
                arr.set_sel = req_idx;
                arr.wen     = 1'b1;
                msk.valid   = 1'b0;   // frame invalid until the last beat
                if (!same_req) begin
                    next_state = LOOKUP;
                end else begin
                    mem.ren  = 1'b1;
                    mem.addr = mem_addr;
                    if (beat_done) begin
                        cnt_en             = 1'b1;
                        next_mem_addr      = mem_addr + 32'd4;
                        wr.data[fill_cnt]  = mem.rdata;
                        msk.data[fill_cnt] = '0;
                    end
                    if (last_beat) begin
                        wr.valid   = 1'b1;
                        wr.tag     = req_tag;
                        msk.tag    = '0;
                        msk.dirty  = 1'b0;
                        next_state = LOOKUP;   // held request hits there
                    end
                end
            end
            WRITEBACK: begin
                arr.set_sel = req_idx;
                if (!same_req) begin
                    next_state = LOOKUP;   // frame keeps its dirty data
                end else begin
                    mem.wen   = 1'b1;
                    mem.addr  = mem_addr;
                    mem.wdata = rd.data[fill_cnt];
                    if (beat_done) begin
                        cnt_en        = 1'b1;
                        next_mem_addr = mem_addr + 32'd4;
                    end
                    if (last_beat) begin
                        arr.wen       = 1'b1;
                        msk.valid     = 1'b0;
                        msk.dirty     = 1'b0;
                        next_mem_addr = blk_addr(req_tag, req_idx, '0);
                        next_state    = FETCH;
                    end
                end
            end
            FLUSH: begin
                arr.set_sel = walk_set;
                if (walk_finish) begin
                    flush_done   = 1'b1;
                    walk_restart = 1'b1;
                    next_state   = LOOKUP;
                end else if (rd.valid && rd.dirty) begin
                    mem.wen   = 1'b1;
                    mem.addr  = blk_addr(rd.tag, walk_set, walk_word);
                    mem.wdata = rd.data[walk_word];
                    if (beat_done) begin
                        walk_advance = 1'b1;
                        if (walk_word == BLK_W'(BLOCK_SIZE - 1)) begin
                            arr.wen = 1'b1;   // last word out, drop the frame
                            msk     = '0;
                        end
                    end
                end else begin
                    arr.wen      = 1'b1;
                    msk          = '0;
                    walk_advance = 1'b1;
                    walk_skip    = 1'b1;
                end
            end
            default: next_state = INIT;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= INIT;
            flush_req <= 1'b0;
            fill_cnt  <= '0;
        end else begin
            state     <= next_state;
            flush_req <= (flush_req | flush) & (state != FLUSH);
            if (cnt_clr || (cnt_en && last_beat))
                fill_cnt <= '0;
            else if (cnt_en)
                fill_cnt <= fill_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        mem_addr <= next_mem_addr;
        req_addr <= next_req_addr;
    end

    mem_excl_a: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(mem.ren && mem.wen)
    );

    // walk has wrapped back to set 0, which it dropped on its first step
    flush_done_a: assert property (
        @(posedge CLK) disable iff (!nRST)
        flush_done |-> (state == FLUSH) && !rd.valid
    );

endmodule

// ==== cache/set_walker.sv ====
// set and word counter for the reset sweep and the flush walk
// steps a word or a whole block, wraps word into set and set into finish

module set_walker import cache_pkg::*; #(
    parameter word_t CACHE_SIZE = DEF_CACHE_SIZE,
    parameter word_t BLOCK_SIZE = DEF_BLOCK_SIZE,
    localparam int   N_SETS     = CACHE_SIZE / 4 / BLOCK_SIZE,
    localparam int   SET_W      = $clog2(N_SETS),
    localparam int   BLK_W      = ($clog2(BLOCK_SIZE) > 0) ? $clog2(BLOCK_SIZE) : 1
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             restart,
    input  logic             advance,
    input  logic             skip_block,
    output logic [SET_W-1:0] set_idx,
    output logic [BLK_W-1:0] word_idx,
    output logic             finish
);

    logic last_word;

    assign last_word = (word_idx == BLK_W'(BLOCK_SIZE - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            set_idx  <= '0;
            word_idx <= '0;
            finish   <= 1'b0;
        end else if (restart) begin
            set_idx  <= '0;
            word_idx <= '0;
            finish   <= 1'b0;
        end else if (advance && !finish) begin
            if (skip_block || last_word) begin
                // next set, carry out of the top set raises finish
                word_idx          <= '0;
                {finish, set_idx} <= (SET_W + 1)'(set_idx) + 1'b1;
            end else begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    word_range_a: assert property (
        @(posedge CLK) disable iff (!nRST)
        word_idx < BLOCK_SIZE
    );

endmodule

// ==== cache/cache_array.sv ====
// cache frame storage, one frame per set
// frame = {valid, dirty, tag, data words}, combinational read, bit-masked write

module cache_array import cache_pkg::*; #(
    parameter word_t CACHE_SIZE = DEF_CACHE_SIZE,
    parameter word_t BLOCK_SIZE = DEF_BLOCK_SIZE
) (
    input logic          CLK,
    input logic          nRST,
    cache_array_if.array arr
);

    localparam int N_SETS  = CACHE_SIZE / 4 / BLOCK_SIZE;
    localparam int SET_W   = $clog2(N_SETS);
    localparam int OFF_W   = $clog2(BLOCK_SIZE);
    localparam int TAG_W   = WORD_W - SET_W - OFF_W - 2;
    localparam int FRAME_W = 2 + TAG_W + BLOCK_SIZE * WORD_W;

    logic [FRAME_W-1:0] frames [N_SETS];

    assign arr.rframe = frames[arr.set_sel];

    // keep old bits where the mask is set
    always_ff @(posedge CLK) begin
        if (arr.wen) begin
            frames[arr.set_sel] <= (frames[arr.set_sel] & arr.wmask)
                                 | (arr.wframe & ~arr.wmask);
        end
    end

    // a write to an unknown set would corrupt the whole array
    sel_known_a: assert property (
        @(posedge CLK) disable iff (!nRST)
        arr.wen |-> !$isunknown(arr.set_sel)
    );

endmodule

// ==== common/cache_array_if.sv ====
// link between the cache controller and the frame storage
// a wmask bit of 0 lets the matching wframe bit into the array

interface cache_array_if #(
    parameter int SET_W   = 6,
    parameter int FRAME_W = 88
) ();

    logic [SET_W-1:0]   set_sel;
    logic               wen;
    logic [FRAME_W-1:0] wframe;
    logic [FRAME_W-1:0] wmask;
    logic [FRAME_W-1:0] rframe;  // frame at set_sel, combinational

    modport ctrl (
        output set_sel, wen, wframe, wmask,
        input  rframe
    );

    modport array (
        input  set_sel, wen, wframe, wmask,
        output rframe
    );

endinterface

// ==== common/gen_bus_if.sv ====
// request/busy bus, used on the processor side and on the memory side
// a request is held until a cycle with busy low, which completes it

interface gen_bus_if import cache_pkg::*; ();

    logic     ren;
    logic     wen;
    word_t    addr;
    word_t    wdata;      // lane aligned
    byte_en_t byte_en;
    word_t    rdata;      // valid in the completing cycle
    logic     busy;

    modport host (
        output ren, wen, addr, wdata, byte_en,
        input  rdata, busy
    );

    modport device (
        input  ren, wen, addr, wdata, byte_en,
        output rdata, busy
    );

endinterface

// ==== common/cache_pkg.sv ====
// cache package
// word and byte-enable types, controller states and default sizes

package cache_pkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [3:0]        byte_en_t;  // one bit per byte lane

    // controller states
    typedef enum logic [2:0] {
        INIT,       // invalidating sweep after reset
        LOOKUP,     // idle, hits and pass-through
        FETCH,      // block fill from memory
        WRITEBACK,  // dirty victim eviction
        FLUSH       // write back and invalidate every set
    } cache_state_e;

    // top level defaults
    localparam word_t DEF_CACHE_SIZE     = 32'd1024;       // bytes, power of two
    localparam word_t DEF_BLOCK_SIZE     = 32'd2;          // words per block, 1 to 8
    localparam word_t DEF_NONCACHE_START = 32'hF000_0000;  // uncached from here up

endpackage
